// File: compile.f
+incdir+hw
hw/rename_pkg.sv
hw/lane_compact.sv
hw/rename_ctrl.sv
hw/map_table.sv
hw/operand_rename.sv
hw/rename_result.sv
hw/rename_top.sv
tb/rename_sva.sv
tb/rename_tb.sv

// File: hw/lane_compact.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module lane_compact (
	input  rename_pkg::lane_mask_t                in_valid,
	output rename_pkg::lane_mask_t [`RN_LANES-1:0] lane_sel,
	output rename_pkg::lane_mask_t                packed_valid
);

	// output lane k takes the k-th valid input lane
	// lane_sel[k] is one-hot over the input lanes, or zero when
	// fewer than k+1 input lanes are valid
	always_comb begin : nth_valid
		int seen;

		lane_sel = '0;
		packed_valid = '0;
		for (int k = 0; k < `RN_LANES; k++) begin
			seen = 0;
			for (int i = 0; i < `RN_LANES; i++) begin
				if (in_valid[i]) begin
					if (seen == k) begin
						lane_sel[k][i] = 1'b1;
						packed_valid[k] = 1'b1;
					end
					seen = seen + 1;
				end
			end
		end
	end

endmodule

// File: hw/map_table.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module map_table (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      flush,
	input  rename_pkg::lane_mask_t                    wr_en,
	input  rename_pkg::arch_reg_t  [`RN_LANES-1:0]    wr_rd,
	input  rename_pkg::station_t   [`RN_LANES-1:0]    wr_station,
	input  rename_pkg::station_mask_t                 commit_done,
	output logic                   [`RN_NREGS-1:0]    map_valid,
	output rename_pkg::station_t   [`RN_NREGS-1:0]    map_station
);

	// entries exist for x1..x31 only
	logic                 [`RN_NREGS-1:1] ent_valid;
	rename_pkg::station_t [`RN_NREGS-1:1] ent_station;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			ent_valid <= '0;
		end else begin
			for (int r = 1; r < `RN_NREGS; r++) begin
				// completed writer, register is architectural again
				if (ent_valid[r] && commit_done[ent_station[r]]) begin
					ent_valid[r] <= 1'b0;
				end
				// later lanes are newer, so the last match wins
				for (int l = 0; l < `RN_LANES; l++) begin
					if (wr_en[l] && wr_rd[l] == rename_pkg::arch_reg_t'(r)) begin
						ent_valid[r] <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int r = 1; r < `RN_NREGS; r++) begin
			for (int l = 0; l < `RN_LANES; l++) begin
				if (wr_en[l] && wr_rd[l] == rename_pkg::arch_reg_t'(r)) begin
					ent_station[r] <= wr_station[l];
				end
			end
		end
	end

	// x0 reads as never mapped
	assign map_valid = {ent_valid, 1'b0};
	assign map_station = {ent_station, rename_pkg::station_t'(0)};

endmodule

// File: hw/operand_rename.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module operand_rename (
	input  rename_pkg::arch_reg_t  [`RN_LANES-1:0]    in_rs1,
	input  rename_pkg::arch_reg_t  [`RN_LANES-1:0]    in_rs2,
	input  rename_pkg::arch_reg_t  [`RN_LANES-1:0]    in_rd,
	input  rename_pkg::lane_mask_t                    in_makes_rd,
	input  rename_pkg::lane_mask_t [`RN_LANES-1:0]    lane_sel,
	input  rename_pkg::lane_mask_t                    packed_valid,
	input  logic                                      accept,
	input  rename_pkg::station_t                      base_station,
	input  logic                   [`RN_NREGS-1:0]    map_valid,
	input  rename_pkg::station_t   [`RN_NREGS-1:0]    map_station,
	input  rename_pkg::station_mask_t                 commit_done,
	output rename_pkg::lane_mask_t                    wr_en,
	output rename_pkg::arch_reg_t  [`RN_LANES-1:0]    wr_rd,
	output rename_pkg::station_t   [`RN_LANES-1:0]    wr_station,
	output rename_pkg::lane_mask_t                    ren_valid,
	output rename_pkg::rn_tag_t    [`RN_LANES-1:0]    ren_rs1,
	output rename_pkg::rn_tag_t    [`RN_LANES-1:0]    ren_rs2,
	output rename_pkg::arch_reg_t  [`RN_LANES-1:0]    ren_rd,
	output rename_pkg::station_t   [`RN_LANES-1:0]    ren_rd_station,
	output rename_pkg::lane_mask_t                    ren_makes_rd
);

	// fields after compaction
	rename_pkg::arch_reg_t [`RN_LANES-1:0] p_rs1;
	rename_pkg::arch_reg_t [`RN_LANES-1:0] p_rs2;
	rename_pkg::arch_reg_t [`RN_LANES-1:0] p_rd;
	rename_pkg::lane_mask_t                p_makes;
	rename_pkg::station_t  [`RN_LANES-1:0] lane_station;

	// newest writer of src as seen by packed lane 'lane'
	// earlier lanes of the same bundle are newer than the map
	function automatic rename_pkg::rn_tag_t lookup(input rename_pkg::arch_reg_t src,
			input int lane);
		logic                 hit;
		rename_pkg::station_t st;
		rename_pkg::rn_tag_t  tag;

		hit = 1'b0;
		st = '0;
		tag = '0;
		if (src != '0) begin
			if (map_valid[src]) begin
				hit = 1'b1;
				st = map_station[src];
			end
			for (int j = 0; j < `RN_LANES; j++) begin
				if (j < lane && packed_valid[j] && p_makes[j] && p_rd[j] == src) begin
					hit = 1'b1;
					st = lane_station[j];
				end
			end
		end
		// commit bypass, a station finishing this cycle reads from the register file
		if (hit && !commit_done[st]) begin
			tag[$bits(rename_pkg::rn_tag_t)-1] = 1'b1;
			tag[`RN_LNCOMMIT-1:0] = st;
		end else begin
			tag[4:0] = src;
		end
		return tag;
	endfunction

	// one-hot mux from the raw lanes
	always_comb begin
		p_rs1 = '0;
		p_rs2 = '0;
		p_rd = '0;
		p_makes = '0;
		for (int k = 0; k < `RN_LANES; k++) begin
			lane_station[k] = base_station + rename_pkg::station_t'(k);
			for (int i = 0; i < `RN_LANES; i++) begin
				if (lane_sel[k][i]) begin
					p_rs1[k] = in_rs1[i];
					p_rs2[k] = in_rs2[i];
					p_rd[k] = in_rd[i];
					p_makes[k] = in_makes_rd[i];
				end
			end
		end
	end

	always_comb begin
		for (int k = 0; k < `RN_LANES; k++) begin
			ren_rs1[k] = lookup(p_rs1[k], k);
			ren_rs2[k] = lookup(p_rs2[k], k);
			wr_en[k] = accept && packed_valid[k] && p_makes[k] && (p_rd[k] != '0);
		end
	end

	assign wr_rd = p_rd;
	assign wr_station = lane_station;

	assign ren_valid = packed_valid & {`RN_LANES{accept}};
	assign ren_rd = p_rd;
	assign ren_rd_station = lane_station;
	assign ren_makes_rd = p_makes;

endmodule

// File: hw/rename_ctrl.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_ctrl (
	input  logic                        clk,
	input  logic                        reset,
	input  rename_pkg::lane_mask_t      in_valid,
	input  rename_pkg::station_count_t  free_stations,
	input  logic                        flush,
	output logic                        stall,
	output logic                        accept,
	output rename_pkg::station_t        base_station
);

	rename_pkg::lane_count_t valid_count;

	// next station to hand out, lane k of a bundle gets alloc_ptr+k
	rename_pkg::station_t alloc_ptr;

	// population count of the incoming bundle
	always_comb begin
		valid_count = '0;
		for (int i = 0; i < `RN_LANES; i++) begin
			valid_count = valid_count + rename_pkg::lane_count_t'(in_valid[i]);
		end
	end

	// whole bundle waits when it does not fit in the free stations
	// a flush overrides the stall, the bundle is dropped anyway
	assign stall = !flush &&
		(rename_pkg::station_count_t'(valid_count) > free_stations);

	assign accept = !flush && !stall && (valid_count != '0);

	// ring pointer wraps through the width of station_t
	always_ff @(posedge clk) begin
		if (reset) begin
			alloc_ptr <= '0;
		end else if (accept) begin
			alloc_ptr <= alloc_ptr + rename_pkg::station_t'(valid_count);
		end
	end

	assign base_station = alloc_ptr;

endmodule

// File: hw/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// instructions per decode bundle
`define RN_LANES 4

// commit stations in the ring
`define RN_NCOMMIT 16

// bits in a station index
`define RN_LNCOMMIT 4

// architectural integer registers, x0 is never renamed
`define RN_NREGS 32

`endif

// File: hw/rename_pkg.sv
`include "rename_defines.svh"

package rename_pkg;

	// architectural register number
	typedef logic [4:0] arch_reg_t;

	// commit station index
	typedef logic [`RN_LNCOMMIT-1:0] station_t;

	// renamed operand, msb set means pending station in the low bits,
	// msb clear means architectural register in the low five bits
	typedef logic [((`RN_LNCOMMIT > 5) ? `RN_LNCOMMIT : 5):0] rn_tag_t;

	// one bit per bundle lane
	typedef logic [`RN_LANES-1:0] lane_mask_t;

	// number of lanes, 0 to RN_LANES
	typedef logic [2:0] lane_count_t;

	// one bit per commit station
	typedef logic [`RN_NCOMMIT-1:0] station_mask_t;

	// number of stations, 0 to RN_NCOMMIT
	typedef logic [`RN_LNCOMMIT:0] station_count_t;

endpackage

// File: hw/rename_result.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_result (
	input  logic                                      clk,
	input  logic                                      reset,
	input  rename_pkg::lane_mask_t                    ren_valid,
	input  rename_pkg::rn_tag_t    [`RN_LANES-1:0]    ren_rs1,
	input  rename_pkg::rn_tag_t    [`RN_LANES-1:0]    ren_rs2,
	input  rename_pkg::arch_reg_t  [`RN_LANES-1:0]    ren_rd,
	input  rename_pkg::station_t   [`RN_LANES-1:0]    ren_rd_station,
	input  rename_pkg::lane_mask_t                    ren_makes_rd,
	output rename_pkg::lane_mask_t                    out_valid,
	output rename_pkg::rn_tag_t    [`RN_LANES-1:0]    out_rs1,
	output rename_pkg::rn_tag_t    [`RN_LANES-1:0]    out_rs2,
	output rename_pkg::arch_reg_t  [`RN_LANES-1:0]    out_rd,
	output rename_pkg::station_t   [`RN_LANES-1:0]    out_rd_station,
	output rename_pkg::lane_mask_t                    out_makes_rd
);

	// lane valids, already zero on stall or flush
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= '0;
		end else begin
			out_valid <= ren_valid;
		end
	end

	// operand fields, only meaningful where out_valid is set
	always_ff @(posedge clk) begin
		out_rs1 <= ren_rs1;
		out_rs2 <= ren_rs2;
		out_rd <= ren_rd;
		out_rd_station <= ren_rd_station;
		out_makes_rd <= ren_makes_rd;
	end

endmodule

// File: hw/rename_top.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_top (
	input  logic                                      clk,
	input  logic                                      reset,
	input  rename_pkg::lane_mask_t                    in_valid,
	input  rename_pkg::arch_reg_t  [`RN_LANES-1:0]    in_rs1,
	input  rename_pkg::arch_reg_t  [`RN_LANES-1:0]    in_rs2,
	input  rename_pkg::arch_reg_t  [`RN_LANES-1:0]    in_rd,
	input  rename_pkg::lane_mask_t                    in_makes_rd,
	input  rename_pkg::station_count_t                free_stations,
	input  rename_pkg::station_mask_t                 commit_done,
	input  logic                                      flush,
	output logic                                      stall,
	output rename_pkg::lane_mask_t                    out_valid,
	output rename_pkg::rn_tag_t    [`RN_LANES-1:0]    out_rs1,
	output rename_pkg::rn_tag_t    [`RN_LANES-1:0]    out_rs2,
	output rename_pkg::station_t   [`RN_LANES-1:0]    out_rd_station,
	output rename_pkg::arch_reg_t  [`RN_LANES-1:0]    out_rd,
	output rename_pkg::lane_mask_t                    out_makes_rd
);

	rename_pkg::lane_mask_t [`RN_LANES-1:0] lane_sel;
	rename_pkg::lane_mask_t                 packed_valid;
	logic                                   accept;
	rename_pkg::station_t                   base_station;
	logic                   [`RN_NREGS-1:0] map_valid;
	rename_pkg::station_t   [`RN_NREGS-1:0] map_station;
	rename_pkg::lane_mask_t                 wr_en;
	rename_pkg::arch_reg_t  [`RN_LANES-1:0] wr_rd;
	rename_pkg::station_t   [`RN_LANES-1:0] wr_station;
	rename_pkg::lane_mask_t                 ren_valid;
	rename_pkg::rn_tag_t    [`RN_LANES-1:0] ren_rs1;
	rename_pkg::rn_tag_t    [`RN_LANES-1:0] ren_rs2;
	rename_pkg::arch_reg_t  [`RN_LANES-1:0] ren_rd;
	rename_pkg::station_t   [`RN_LANES-1:0] ren_rd_station;
	rename_pkg::lane_mask_t                 ren_makes_rd;

	// decode, pack valid lanes low
	lane_compact lane_compact_i (
		.in_valid     (in_valid),
		.lane_sel     (lane_sel),
		.packed_valid (packed_valid)
	);

	rename_ctrl rename_ctrl_i (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.free_stations (free_stations),
		.flush         (flush),
		.stall         (stall),
		.accept        (accept),
		.base_station  (base_station)
	);

	map_table map_table_i (
		.clk         (clk),
		.reset       (reset),
		.flush       (flush),
		.wr_en       (wr_en),
		.wr_rd       (wr_rd),
		.wr_station  (wr_station),
		.commit_done (commit_done),
		.map_valid   (map_valid),
		.map_station (map_station)
	);

	// execute, sources to tags
	operand_rename operand_rename_i (
		.in_rs1         (in_rs1),
		.in_rs2         (in_rs2),
		.in_rd          (in_rd),
		.in_makes_rd    (in_makes_rd),
		.lane_sel       (lane_sel),
		.packed_valid   (packed_valid),
		.accept         (accept),
		.base_station   (base_station),
		.map_valid      (map_valid),
		.map_station    (map_station),
		.commit_done    (commit_done),
		.wr_en          (wr_en),
		.wr_rd          (wr_rd),
		.wr_station     (wr_station),
		.ren_valid      (ren_valid),
		.ren_rs1        (ren_rs1),
		.ren_rs2        (ren_rs2),
		.ren_rd         (ren_rd),
		.ren_rd_station (ren_rd_station),
		.ren_makes_rd   (ren_makes_rd)
	);

	// result, one register stage to the dispatch side
	rename_result rename_result_i (
		.clk            (clk),
		.reset          (reset),
		.ren_valid      (ren_valid),
		.ren_rs1        (ren_rs1),
		.ren_rs2        (ren_rs2),
		.ren_rd         (ren_rd),
		.ren_rd_station (ren_rd_station),
		.ren_makes_rd   (ren_makes_rd),
		.out_valid      (out_valid),
		.out_rs1        (out_rs1),
		.out_rs2        (out_rs2),
		.out_rd         (out_rd),
		.out_rd_station (out_rd_station),
		.out_makes_rd   (out_makes_rd)
	);

endmodule

// File: run.sh
#!/bin/sh
# build the rename stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module rename_tb \
	-Mdir "$BUILD_DIR" -o rename_sim
if [ $? -ne 0 ]; then
	echo "verilator build did not complete"
	exit 1
fi

"./$BUILD_DIR/rename_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	exit 1
fi
exit 0

// File: tb/rename_sva.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_sva (
	input logic                   clk,
	input logic                   reset,
	input logic                   flush,
	input logic                   stall,
	input rename_pkg::lane_mask_t out_valid
);

	// a bundle is either taken whole or held whole, a held one never reaches the output
	no_stall_with_accept: assert property (
		@(posedge clk) disable iff (reset) stall |=> (out_valid == '0))
		else $error("a stalled bundle reached out_valid");

	// a redirect kills whatever was being renamed
	flush_kills_output: assert property (
		@(posedge clk) disable iff (reset) flush |=> (out_valid == '0))
		else $error("out_valid is set in the cycle after a flush");

	// packed lanes fill from lane 0 up, so the mask is 0000, 0001, 0011, ...
	valid_lanes_contiguous: assert property (
		@(posedge clk) disable iff (reset)
		((out_valid + rename_pkg::lane_mask_t'(1)) & out_valid) == '0)
		else $error("out_valid has a gap above lane 0");

endmodule

// File: tb/rename_tb.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_tb;

	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_CYCLES = 400;
	// the directed tests need about 50 cycles together
	localparam int CYCLE_LIMIT = RESET_CYCLES + 60 + RANDOM_CYCLES + 40;

	logic                                   clk;
	logic                                   reset;
	rename_pkg::lane_mask_t                 in_valid;
	rename_pkg::arch_reg_t  [`RN_LANES-1:0] in_rs1;
	rename_pkg::arch_reg_t  [`RN_LANES-1:0] in_rs2;
	rename_pkg::arch_reg_t  [`RN_LANES-1:0] in_rd;
	rename_pkg::lane_mask_t                 in_makes_rd;
	rename_pkg::station_count_t             free_stations;
	rename_pkg::station_mask_t              commit_done;
	logic                                   flush;
	logic                                   stall;
	rename_pkg::lane_mask_t                 out_valid;
	rename_pkg::rn_tag_t    [`RN_LANES-1:0] out_rs1;
	rename_pkg::rn_tag_t    [`RN_LANES-1:0] out_rs2;
	rename_pkg::station_t   [`RN_LANES-1:0] out_rd_station;
	rename_pkg::arch_reg_t  [`RN_LANES-1:0] out_rd;
	rename_pkg::lane_mask_t                 out_makes_rd;

	// reference model state
	logic [`RN_NREGS-1:0] m_valid;
	rename_pkg::station_t m_station [`RN_NREGS];
	rename_pkg::station_t m_ptr;

	// expected outputs after the coming edge
	rename_pkg::lane_mask_t exp_valid;
	logic                   exp_stall;
	rename_pkg::rn_tag_t    exp_rs1 [`RN_LANES];
	rename_pkg::rn_tag_t    exp_rs2 [`RN_LANES];
	rename_pkg::arch_reg_t  exp_rd [`RN_LANES];
	rename_pkg::station_t   exp_station [`RN_LANES];
	logic                   exp_makes [`RN_LANES];

	logic [31:0] lcg_state = 32'd9;
	string       test_name = "reset";
	int          error_count = 0;
	int          errors_at_start = 0;
	int          tests_run = 0;
	int          tests_bad = 0;
	int          cycle_count = 0;

	rename_top rename_top_i (.*);

	bind rename_top rename_sva rename_sva_i (
		.clk       (clk),
		.reset     (reset),
		.flush     (flush),
		.stall     (stall),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic void check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual == expected) else begin
			$display("Error %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected,
				actual);
			error_count++;
		end
	endfunction

	function automatic void clear_model();
		m_valid = '0;
		m_ptr = '0;
		exp_valid = '0;
		exp_stall = 1'b0;
		for (int r = 0; r < `RN_NREGS; r++) begin
			m_station[r] = '0;
		end
	endfunction

	// tag for src as read by packed lane k, the nearest earlier writer in the bundle wins
	function automatic rename_pkg::rn_tag_t expect_tag(input rename_pkg::arch_reg_t src,
			input int k);
		int                   j;
		logic                 found;
		rename_pkg::station_t st;

		found = 1'b0;
		st = '0;
		if (src == '0) begin
			return rename_pkg::rn_tag_t'({1'b0, src});
		end
		j = k - 1;
		while (j >= 0 && !found) begin
			if (exp_makes[j] && exp_rd[j] == src) begin
				found = 1'b1;
				st = exp_station[j];
			end
			j--;
		end
		if (!found && m_valid[src]) begin
			found = 1'b1;
			st = m_station[src];
		end
		// station finishing now means the register file already has the value
		if (found && !commit_done[st]) begin
			return rename_pkg::rn_tag_t'({2'b10, st});
		end
		return rename_pkg::rn_tag_t'({1'b0, src});
	endfunction

	// one clock edge of the rename stage, seen from the current inputs
	function automatic void step_model();
		int                    n;
		logic                  take;
		rename_pkg::arch_reg_t src1 [`RN_LANES];
		rename_pkg::arch_reg_t src2 [`RN_LANES];

		n = 0;
		for (int i = 0; i < `RN_LANES; i++) begin
			if (in_valid[i]) begin
				src1[n] = in_rs1[i];
				src2[n] = in_rs2[i];
				exp_rd[n] = in_rd[i];
				exp_makes[n] = in_makes_rd[i];
				exp_station[n] = m_ptr + rename_pkg::station_t'(n);
				n++;
			end
		end
		for (int k = 0; k < n; k++) begin
			exp_rs1[k] = expect_tag(src1[k], k);
			exp_rs2[k] = expect_tag(src2[k], k);
		end
		exp_stall = !flush && (n > int'(free_stations));
		take = !flush && !exp_stall && (n > 0);
		exp_valid = take ? rename_pkg::lane_mask_t'((1 << n) - 1) : '0;

		if (flush) begin
			m_valid = '0;
		end else begin
			for (int r = 1; r < `RN_NREGS; r++) begin
				if (m_valid[r] && commit_done[m_station[r]]) begin
					m_valid[r] = 1'b0;
				end
			end
			if (take) begin
				for (int k = 0; k < n; k++) begin
					if (exp_makes[k] && exp_rd[k] != '0) begin
						m_valid[exp_rd[k]] = 1'b1;
						m_station[exp_rd[k]] = exp_station[k];
					end
				end
				m_ptr = m_ptr + rename_pkg::station_t'(n);
			end
		end
	endfunction

	function automatic void check_outputs();
		check_value("out_valid", 32'(exp_valid), 32'(out_valid));
		for (int k = 0; k < `RN_LANES; k++) begin
			if (exp_valid[k]) begin
				check_value($sformatf("lane %0d rs1", k), 32'(exp_rs1[k]), 32'(out_rs1[k]));
				check_value($sformatf("lane %0d rs2", k), 32'(exp_rs2[k]), 32'(out_rs2[k]));
				check_value($sformatf("lane %0d rd", k), 32'(exp_rd[k]), 32'(out_rd[k]));
				check_value($sformatf("lane %0d station", k), 32'(exp_station[k]),
					32'(out_rd_station[k]));
				check_value($sformatf("lane %0d makes_rd", k), 32'(exp_makes[k]),
					32'(out_makes_rd[k]));
			end
		end
	endfunction

	// outputs seen here were registered at the previous edge
	always @(posedge clk) begin : compare
		if (reset) begin
			clear_model();
		end else begin
			check_outputs();
			step_model();
			check_value("stall", 32'(exp_stall), 32'(stall));
		end
	end

	always @(posedge clk) begin : watchdog
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$finish;
		end
	end

	task automatic drive_idle();
		in_valid = '0;
		in_makes_rd = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		in_rd = '0;
		free_stations = rename_pkg::station_count_t'(`RN_NCOMMIT);
		commit_done = '0;
		flush = 1'b0;
	endtask

	task automatic put_lane(input int i, input int rs1, input int rs2, input int rd,
			input logic makes);
		in_valid[i] = 1'b1;
		in_rs1[i] = rename_pkg::arch_reg_t'(rs1);
		in_rs2[i] = rename_pkg::arch_reg_t'(rs2);
		in_rd[i] = rename_pkg::arch_reg_t'(rd);
		in_makes_rd[i] = makes;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
		@(negedge clk);
		drive_idle();
	endtask

	// one idle cycle lets the last bundle reach the compare process
	task automatic finish_test();
		int errs;

		@(negedge clk);
		drive_idle();
		@(negedge clk);
		errs = error_count - errors_at_start;
		tests_run++;
		if (errs != 0) begin
			tests_bad++;
		end
		$display("test %-13s %0d errors", test_name, errs);
	endtask

	task automatic cross_bundle_test();
		start_test("cross_bundle");
		put_lane(0, 0, 0, 5, 1'b1);
		put_lane(2, 0, 0, 6, 1'b1);
		put_lane(3, 0, 0, 7, 1'b0);
		@(negedge clk);
		drive_idle();
		put_lane(0, 5, 6, 1, 1'b1);
		put_lane(1, 7, 0, 2, 1'b1);
		put_lane(2, 0, 5, 0, 1'b0);
		@(negedge clk);
		drive_idle();
		put_lane(0, 1, 2, 5, 1'b1);
		put_lane(3, 5, 6, 0, 1'b0);
		finish_test();
	endtask

	task automatic in_bundle_test();
		start_test("in_bundle");
		put_lane(0, 0, 0, 3, 1'b1);
		put_lane(1, 3, 3, 3, 1'b1);
		put_lane(2, 3, 1, 4, 1'b1);
		put_lane(3, 4, 0, 0, 1'b1);
		@(negedge clk);
		drive_idle();
		// rd without makes_rd must not forward
		put_lane(0, 3, 4, 9, 1'b0);
		put_lane(1, 9, 3, 0, 1'b0);
		finish_test();
	endtask

	task automatic sparse_wrap_test();
		rename_pkg::lane_mask_t masks [5];

		masks = '{4'b1010, 4'b0100, 4'b1001, 4'b1110, 4'b0001};
		start_test("sparse_wrap");
		// 18 stations in all, so the pointer wraps
		for (int b = 0; b < 10; b++) begin
			for (int i = 0; i < `RN_LANES; i++) begin
				if (masks[b % 5][i]) begin
					put_lane(i, (b + i) % 8, i, (b + 2 * i) % 8 + 1, 1'b1);
				end
			end
			@(negedge clk);
			drive_idle();
		end
		finish_test();
	endtask

	task automatic commit_test();
		start_test("commit");
		put_lane(0, 0, 0, 8, 1'b1);
		put_lane(1, 0, 0, 12, 1'b1);
		@(negedge clk);
		drive_idle();
		// x8 completes in the cycle it is read
		commit_done = rename_pkg::station_mask_t'(1) << m_station[8];
		put_lane(0, 8, 12, 13, 1'b1);
		@(negedge clk);
		drive_idle();
		put_lane(0, 12, 8, 0, 1'b0);
		@(negedge clk);
		drive_idle();
		commit_done = rename_pkg::station_mask_t'(1) << m_station[12];
		@(negedge clk);
		drive_idle();
		put_lane(0, 12, 13, 0, 1'b0);
		finish_test();
	endtask

	task automatic stall_test();
		start_test("stall");
		put_lane(0, 0, 0, 14, 1'b1);
		@(negedge clk);
		drive_idle();
		free_stations = 5'd2;
		put_lane(0, 14, 0, 15, 1'b1);
		put_lane(1, 0, 0, 14, 1'b1);
		put_lane(2, 15, 14, 16, 1'b1);
		@(negedge clk);
		free_stations = 5'd0;
		@(negedge clk);
		free_stations = 5'd3;
		@(negedge clk);
		drive_idle();
		put_lane(0, 14, 15, 0, 1'b0);
		put_lane(1, 16, 0, 0, 1'b0);
		finish_test();
	endtask

	task automatic flush_test();
		start_test("flush");
		put_lane(0, 0, 0, 9, 1'b1);
		put_lane(1, 0, 0, 10, 1'b1);
		@(negedge clk);
		drive_idle();
		// no free stations, yet a flush never stalls
		flush = 1'b1;
		free_stations = 5'd0;
		put_lane(0, 9, 10, 11, 1'b1);
		@(negedge clk);
		drive_idle();
		put_lane(0, 9, 10, 17, 1'b1);
		put_lane(1, 11, 17, 0, 1'b0);
		finish_test();
	endtask

	task automatic random_test();
		logic [31:0] r;

		start_test("random");
		for (int c = 0; c < RANDOM_CYCLES; c++) begin
			// upstream keeps its bundle while stall is high
			if (!stall) begin
				r = lcg_next();
				in_valid = rename_pkg::lane_mask_t'(r[19:16]);
				in_makes_rd = rename_pkg::lane_mask_t'(r[23:20]);
				for (int i = 0; i < `RN_LANES; i++) begin
					r = lcg_next();
					in_rs1[i] = rename_pkg::arch_reg_t'(r[18:16]);
					in_rs2[i] = rename_pkg::arch_reg_t'(r[21:19]);
					in_rd[i] = rename_pkg::arch_reg_t'(r[24:22]);
				end
			end
			r = lcg_next();
			free_stations = (r[17:16] == 2'b00) ? rename_pkg::station_count_t'(r[20:18]) : 5'd16;
			commit_done = r[25] ? (rename_pkg::station_mask_t'(1) << r[24:21]) : '0;
			flush = (r[30:27] == 4'hf);
			@(negedge clk);
		end
		finish_test();
	endtask

	initial begin : run
		reset = 1'b1;
		drive_idle();
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		cross_bundle_test();
		in_bundle_test();
		sparse_wrap_test();
		commit_test();
		stall_test();
		flush_test();
		random_test();
		$display("%0d tests run, %0d with errors, %0d errors in all", tests_run, tests_bad,
			error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
